//--- Makefile
SIM := obj_dir/Vdata_mem_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): data_mem.f $(shell cat data_mem.f)
	verilator --binary --timing --assert -f data_mem.f --top-module data_mem_tb

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf obj_dir

//--- bench/data_mem_checker.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem_checker (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      run,
   input  mem_types_pkg::mem_req_t  req,
   input  wire                      uart_we,
   input  wire                      wb_we
);

   logic uart_store;
   logic armed = 1'b0; // at least one edge seen

   assign uart_store = req.valid && req.store && (req.addr == mem_types_pkg::uart_addr);

   always @(posedge clk)
      armed <= 1'b1;

   // back-to-back strobes need back-to-back uart stores
   uart_pulse_chk: assert property (
      @(posedge clk) disable iff (!rst_n)
         (uart_we && $past(uart_we)) |-> ($past(uart_store, 1) && $past(uart_store, 2))
   ) else $error("uart_we high for two cycles without two uart stores");

   wb_we_reset_chk: assert property (
      @(posedge clk) (armed && !$past(rst_n)) |-> !wb_we
   ) else $error("wb.we set in the cycle after reset");

   wb_we_run_chk: assert property (
      @(posedge clk) (armed && !$past(run)) |-> !wb_we
   ) else $error("wb.we set after a request with run low");

   uart_we_reset_chk: assert property (
      @(posedge clk) (armed && !$past(rst_n)) |-> !uart_we
   ) else $error("uart_we set in the cycle after reset");

endmodule

bind data_mem_top data_mem_checker chk (
   .clk     (clk),
   .rst_n   (rst_n),
   .run     (run),
   .req     (req),
   .uart_we (uart_we),
   .wb_we   (wb.we)
);

`default_nettype wire

//--- bench/data_mem_tb.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem_tb;

   localparam int n_fill = 1024 + 32;
   localparam int n_word = 128;
   localparam int n_sub = 64;
   localparam int n_ld = 64;
   localparam int n_uart = 12;
   localparam int n_alu = 64;
   localparam int total_cycles = 5 + n_fill + n_word + n_sub + n_ld + n_uart + n_alu + 6 * 3;

   logic                      clk = 1'b0;
   logic                      rst_n;
   logic                      run;
   mem_types_pkg::mem_req_t   req;
   pipe_types_pkg::wb_side_t  side;
   logic [31:0]               load_addr;
   logic [31:0]               load_data;
   logic                      load_we;
   pipe_types_pkg::wb_out_t   wb;
   logic [31:0]               uart_data;
   logic                      uart_we;

   integer      seed = 32'hc1f72090;
   logic [7:0]  shadow [4096];
   string       test_name = "none";
   int          errors = 0;
   int          test_errs = 0;
   int          checks = 0;
   int          tests_run = 0;

   // expected outputs of the request in flight
   logic        pend_valid = 1'b0;
   logic        pend_we;
   logic [4:0]  pend_rd;
   logic [31:0] pend_wdata;
   logic        pend_uart_we;
   logic [31:0] pend_uart_data;
   string       pend_name;
   logic        cur_valid = 1'b0;
   logic        cur_we;
   logic [4:0]  cur_rd;
   logic [31:0] cur_wdata;
   logic        cur_uart_we;
   logic [31:0] cur_uart_data;
   string       cur_name;

   data_mem_top #(.addr_bits(12)) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .req       (req),
      .side      (side),
      .load_addr (load_addr),
      .load_data (load_data),
      .load_we   (load_we),
      .wb        (wb),
      .uart_data (uart_data),
      .uart_we   (uart_we)
   );

   initial begin
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] rnd();
      rnd = $random(seed);
   endfunction

   function automatic logic [31:0] fill_pattern(input logic [31:0] a);
      return (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};
   endfunction

   function automatic int size_bytes(input mem_types_pkg::mem_size_e sz);
      if (sz == mem_types_pkg::size_byte)
         return 1;
      else if (sz == mem_types_pkg::size_half)
         return 2;
      return 4;
   endfunction

   // lanes past 3 read as the fill byte
   function automatic logic [31:0] expect_load(input logic [31:0] a,
                                               input mem_types_pkg::mem_size_e sz,
                                               input logic uns);
      logic [7:0]  fill;
      logic [31:0] r;
      int          nb;
      int          off;
      int          base;
      base = {20'h0, a[11:2], 2'b00};
      off = a[1:0];
      nb = size_bytes(sz);
      fill = {8{!uns && shadow[base + 3][7]}};
      r = 32'h0;
      for (int k = 0; k < 4; k++) begin
         if (k >= nb)
            r[8*k +: 8] = {8{!uns && r[8*nb-1]}};
         else if (off + k < 4)
            r[8*k +: 8] = shadow[base + off + k];
         else
            r[8*k +: 8] = fill;
      end
      return r;
   endfunction

   // store bytes start at the offset lane and drop past lane 3
   function automatic void place_store(input mem_types_pkg::mem_size_e sz,
                                       input logic [1:0] off, input logic [31:0] wd,
                                       output logic [31:0] data, output logic [3:0] be);
      int nb;
      int lane;
      nb = size_bytes(sz);
      data = 32'h0;
      be = 4'b0000;
      for (int k = 0; k < nb; k++) begin
         lane = off + k;
         if (lane < 4) begin
            data[8*lane +: 8] = wd[8*k +: 8];
            be[lane] = 1'b1;
         end
      end
   endfunction

   task automatic step(input logic v, input logic st, input logic [31:0] addr,
                       input mem_types_pkg::mem_size_e sz, input logic [31:0] wd,
                       input logic uns, input logic mtr, input logic rwe, input logic r,
                       input logic lw, input logic [31:0] laddr, input logic [31:0] ldata);
      logic [31:0] alu;
      logic [31:0] t;
      logic [4:0]  rd;
      logic [31:0] exp_data;
      logic [31:0] ua;
      logic [3:0]  be;
      logic        uart_hit;
      alu = rnd();
      t = rnd();
      rd = t[4:0];
      uart_hit = (addr == mem_types_pkg::uart_addr);
      if (!mtr)
         exp_data = alu;
      else if (uart_hit)
         exp_data = 32'h0;
      else
         exp_data = expect_load(addr, sz, uns); // before this cycle's store
      place_store(sz, addr[1:0], wd, ua, be);
      if (v && st && !uart_hit) begin
         for (int i = 0; i < 4; i++)
            if (be[i])
               shadow[{addr[11:2], i[1:0]}] = ua[8*i +: 8];
      end else if (lw) begin
         for (int i = 0; i < 4; i++)
            shadow[{laddr[11:2], i[1:0]}] = ldata[8*i +: 8];
      end
      @(posedge clk);
      req.addr        <= addr;
      req.size        <= sz;
      req.wdata       <= wd;
      req.store       <= st;
      req.unsigned_ld <= uns;
      req.valid       <= v;
      side.rd         <= rd;
      side.reg_we     <= rwe;
      side.mem_to_reg <= mtr;
      side.alu_result <= alu;
      run             <= r;
      load_we         <= lw;
      load_addr       <= laddr;
      load_data       <= ldata;
      pend_valid      <= 1'b1;
      pend_we         <= r && rwe;
      pend_rd         <= rd;
      pend_wdata      <= exp_data;
      pend_uart_we    <= v && st && uart_hit;
      pend_uart_data  <= ua;
      pend_name       <= test_name;
   endtask

   task automatic load(input logic [31:0] a, input mem_types_pkg::mem_size_e sz,
                       input logic uns);
      step(1'b1, 1'b0, a, sz, rnd(), uns, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0, 32'h0);
   endtask

   task automatic store(input logic [31:0] a, input mem_types_pkg::mem_size_e sz,
                        input logic [31:0] d);
      step(1'b1, 1'b1, a, sz, d, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h0, 32'h0);
   endtask

   task automatic loader_write(input logic [31:0] a, input logic [31:0] d);
      step(1'b0, 1'b0, 32'h0, mem_types_pkg::size_word, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1,
           1'b1, a, d);
   endtask

   task automatic idle();
      step(1'b0, 1'b0, 32'h0, mem_types_pkg::size_word, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0,
           1'b0, 32'h0, 32'h0);
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      idle();
      idle();
      @(posedge clk);
      @(negedge clk);
      #1;
      tests_run++;
      $display("test %s finished with %0d errors", test_name, test_errs);
   endtask

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("mismatch %s %s expected %h actual %h", cur_name, what, exp, act);
      errors++;
      test_errs++;
   endtask

   always @(posedge clk) begin
      cur_valid     <= pend_valid;
      cur_we        <= pend_we;
      cur_rd        <= pend_rd;
      cur_wdata     <= pend_wdata;
      cur_uart_we   <= pend_uart_we;
      cur_uart_data <= pend_uart_data;
      cur_name      <= pend_name;
   end

   // outputs checked one cycle after each request
   always @(negedge clk) begin
      if (cur_valid) begin
         checks++;
         assert (wb.we === cur_we) else report_mismatch("wb.we", {31'h0, cur_we}, {31'h0, wb.we});
         assert (wb.rd === cur_rd) else report_mismatch("wb.rd", {27'h0, cur_rd}, {27'h0, wb.rd});
         assert (wb.wdata === cur_wdata) else report_mismatch("wb.wdata", cur_wdata, wb.wdata);
      end
   end

   uart_we_match: assert property (@(negedge clk) disable iff (!cur_valid)
      uart_we == cur_uart_we)
      else report_mismatch("uart_we", {31'h0, cur_uart_we}, {31'h0, uart_we});

   uart_data_match: assert property (@(negedge clk) disable iff (!cur_valid)
      cur_uart_we |-> (uart_data == cur_uart_data))
      else report_mismatch("uart_data", cur_uart_data, uart_data);

   initial begin
      #(total_cycles * 4 + 200);
      $display("watchdog expired, run did not finish in time");
      $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      logic [31:0] a;
      logic [31:0] t;
      mem_types_pkg::mem_size_e sz;
      rst_n = 1'b0;
      run = 1'b0;
      req = '0;
      side = '0;
      load_addr = 32'h0;
      load_data = 32'h0;
      load_we = 1'b0;
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;

      begin_test("loader_fill");
      for (int i = 0; i < 1024; i++) begin
         a = {20'h0, i[9:0], 2'b00};
         loader_write(a, fill_pattern(a));
      end
      repeat (32) load(rnd() & 32'h0000_0ffc, mem_types_pkg::size_word, 1'b0);
      end_test();

      begin_test("word_store_load");
      repeat (64) begin
         a = rnd() & 32'h0000_0ffc;
         store(a, mem_types_pkg::size_word, rnd());
         load(a, mem_types_pkg::size_word, 1'b0);
      end
      end_test();

      begin_test("sub_word_store");
      repeat (4) begin
         for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 2; k++) begin
               sz = (k == 0) ? mem_types_pkg::size_byte : mem_types_pkg::size_half;
               a = (rnd() & 32'h0000_0ffc) | {30'h0, off[1:0]};
               store(a, sz, rnd());
               load(a & 32'hffff_fffc, mem_types_pkg::size_word, 1'b0);
            end
         end
      end
      end_test();

      begin_test("sub_word_load");
      repeat (4) begin
         for (int off = 0; off < 4; off++) begin
            for (int k = 0; k < 4; k++) begin
               sz = k[0] ? mem_types_pkg::size_half : mem_types_pkg::size_byte;
               a = (rnd() & 32'h0000_0ffc) | {30'h0, off[1:0]};
               load(a, sz, k[1]);
            end
         end
      end
      end_test();

      begin_test("uart_store");
      for (int k = 0; k < 3; k++) begin
         sz = (k == 0) ? mem_types_pkg::size_byte :
              (k == 1) ? mem_types_pkg::size_half : mem_types_pkg::size_word;
         store(mem_types_pkg::uart_addr, sz, rnd());
         store(mem_types_pkg::uart_addr, sz, rnd()); // back to back strobe
         load(mem_types_pkg::uart_addr, sz, 1'b0);
         load(32'h0, mem_types_pkg::size_word, 1'b0); // ram word 0 untouched
      end
      end_test();

      begin_test("alu_result_run");
      repeat (64) begin
         t = rnd();
         step(t[0], 1'b0, rnd() & 32'h0000_0ffc, mem_types_pkg::size_word, rnd(), 1'b0,
              1'b0, t[1], t[2], 1'b0, 32'h0, 32'h0);
      end
      end_test();

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- data_mem.f
hdl/mem_types_pkg.sv
hdl/pipe_types_pkg.sv
hdl/store_align.sv
hdl/byte_lane_ram.sv
hdl/load_extract.sv
hdl/mem_access_ctrl.sv
hdl/data_mem_top.sv
bench/data_mem_checker.sv
bench/data_mem_tb.sv

//--- hdl/byte_lane_ram.sv
`timescale 1ns/100ps
`default_nettype none

module byte_lane_ram #(
   parameter int addr_bits = 12
) (
   input  wire                  clk,
   input  wire [addr_bits-3:0]  rd_index,
   output logic [7:0]           rd_byte,
   input  wire [addr_bits-3:0]  wr_index,
   input  wire [7:0]            wr_byte,
   input  wire                  wr_en
);

   localparam int depth = 1 << (addr_bits - 2);

   logic [7:0] mem [depth];

   // read returns the old byte on a same-cycle write
   always_ff @(posedge clk) begin
      if (wr_en)
         mem[wr_index] <= wr_byte;
      rd_byte <= mem[rd_index];
   end

endmodule

`default_nettype wire

//--- hdl/data_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module data_mem_top #(
   parameter int addr_bits = 12
) (
   input  wire                       clk,
   input  wire                       rst_n,
   input  wire                       run,
   input  mem_types_pkg::mem_req_t   req,
   input  pipe_types_pkg::wb_side_t  side,
   input  wire [31:0]                load_addr,
   input  wire [31:0]                load_data,
   input  wire                       load_we,
   output pipe_types_pkg::wb_out_t   wb,
   output logic [31:0]               uart_data,
   output logic                      uart_we
);

   mem_types_pkg::data_word_u lane_wdata;
   mem_types_pkg::data_word_u wr_data;
   mem_types_pkg::data_word_u rd_word;
   logic [3:0]                lane_be;
   logic [3:0]                wr_en;
   logic [addr_bits-3:0]      wr_index;
   logic [addr_bits-3:0]      rd_index;
   logic [31:0]               ld_word;
   logic [1:0]                ld_offset;
   mem_types_pkg::mem_size_e  ld_size;
   logic                      ld_unsigned;

   mem_access_ctrl #(.addr_bits(addr_bits)) ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .run         (run),
      .req         (req),
      .side        (side),
      .load_addr   (load_addr),
      .load_data   (load_data),
      .load_we     (load_we),
      .lane_wdata  (lane_wdata),
      .lane_be     (lane_be),
      .ld_word     (ld_word),
      .wr_index    (wr_index),
      .wr_data     (wr_data),
      .wr_en       (wr_en),
      .rd_index    (rd_index),
      .ld_offset   (ld_offset),
      .ld_size     (ld_size),
      .ld_unsigned (ld_unsigned),
      .wb          (wb),
      .uart_data   (uart_data),
      .uart_we     (uart_we)
   );

   store_align align (
      .size       (req.size),
      .offset     (req.addr[1:0]),
      .wdata      (req.wdata),
      .lane_wdata (lane_wdata),
      .lane_be    (lane_be)
   );

   byte_lane_ram #(.addr_bits(addr_bits)) lane_0 (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_byte  (rd_word.lanes[0]),
      .wr_index (wr_index),
      .wr_byte  (wr_data.lanes[0]),
      .wr_en    (wr_en[0])
   );

   byte_lane_ram #(.addr_bits(addr_bits)) lane_1 (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_byte  (rd_word.lanes[1]),
      .wr_index (wr_index),
      .wr_byte  (wr_data.lanes[1]),
      .wr_en    (wr_en[1])
   );

   byte_lane_ram #(.addr_bits(addr_bits)) lane_2 (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_byte  (rd_word.lanes[2]),
      .wr_index (wr_index),
      .wr_byte  (wr_data.lanes[2]),
      .wr_en    (wr_en[2])
   );

   byte_lane_ram #(.addr_bits(addr_bits)) lane_3 (
      .clk      (clk),
      .rd_index (rd_index),
      .rd_byte  (rd_word.lanes[3]),
      .wr_index (wr_index),
      .wr_byte  (wr_data.lanes[3]),
      .wr_en    (wr_en[3])
   );

   load_extract extract (
      .word        (rd_word),
      .offset      (ld_offset),
      .size        (ld_size),
      .unsigned_ld (ld_unsigned),
      .ld_word     (ld_word)
   );

endmodule

`default_nettype wire

//--- hdl/load_extract.sv
`timescale 1ns/100ps
`default_nettype none

module load_extract (
   input  mem_types_pkg::data_word_u  word,
   input  wire [1:0]                  offset,
   input  mem_types_pkg::mem_size_e   size,
   input  wire                        unsigned_ld,
   output logic [31:0]                ld_word
);

   logic        fill;
   logic [63:0] wide;
   logic [63:0] shifted;
   logic [7:0]  sel_byte;
   logic [15:0] sel_half;

   // top fill for the word shift
   assign fill    = !unsigned_ld && word.word[31];
   assign wide    = {{32{fill}}, word.word};
   assign shifted = wide >> {offset, 3'b000};

   assign sel_byte = word.lanes[offset];
   assign sel_half = shifted[15:0];

   always_comb begin
      case (size)
         mem_types_pkg::size_byte: begin
            if (unsigned_ld)
               ld_word = {24'h00_0000, sel_byte};
            else
               ld_word = {{24{sel_byte[7]}}, sel_byte};
         end
         mem_types_pkg::size_half: begin
            if (unsigned_ld)
               ld_word = {16'h0000, sel_half};
            else
               ld_word = {{16{sel_half[15]}}, sel_half};
         end
         default:
            ld_word = shifted[31:0]; // word, also size 3
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/mem_access_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl #(
   parameter int addr_bits = 12
) (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire                        run,
   input  mem_types_pkg::mem_req_t    req,
   input  pipe_types_pkg::wb_side_t   side,
   input  wire [31:0]                 load_addr,
   input  wire [31:0]                 load_data,
   input  wire                        load_we,
   input  mem_types_pkg::data_word_u  lane_wdata,
   input  wire [3:0]                  lane_be,
   input  wire [31:0]                 ld_word,
   output logic [addr_bits-3:0]       wr_index,
   output mem_types_pkg::data_word_u  wr_data,
   output logic [3:0]                 wr_en,
   output logic [addr_bits-3:0]       rd_index,
   output logic [1:0]                 ld_offset,
   output mem_types_pkg::mem_size_e   ld_size,
   output logic                       ld_unsigned,
   output pipe_types_pkg::wb_out_t    wb,
   output logic [31:0]                uart_data,
   output logic                       uart_we
);

   logic        uart_hit;
   logic        core_store;
   logic        ram_store;
   logic        uart_store;
   logic        we_r;
   logic [4:0]  rd_r;
   logic        mem_to_reg_r;
   logic [31:0] alu_result_r;
   logic        uart_ld_r;

   assign uart_hit   = (req.addr == mem_types_pkg::uart_addr);
   assign core_store = req.valid && req.store;
   assign ram_store  = core_store && !uart_hit;
   assign uart_store = core_store && uart_hit;

   // all lanes read every cycle
   assign rd_index = req.addr[addr_bits-1:2];

   // core store wins, a colliding loader word is lost
   always_comb begin
      wr_index = req.addr[addr_bits-1:2];
      wr_data  = lane_wdata;
      wr_en    = 4'b0000;
      if (ram_store) begin
         wr_en = lane_be;
      end else if (load_we) begin
         wr_index     = load_addr[addr_bits-1:2];
         wr_data.word = load_data;
         wr_en        = 4'b1111;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         uart_we <= 1'b0;
         we_r    <= 1'b0;
      end else begin
         uart_we <= uart_store;
         we_r    <= run && side.reg_we;
      end
   end

   // payload, follows the read by one cycle
   always_ff @(posedge clk) begin
      if (uart_store)
         uart_data <= lane_wdata.word; // already positioned by offset
      rd_r         <= side.rd;
      mem_to_reg_r <= side.mem_to_reg;
      alu_result_r <= side.alu_result;
      uart_ld_r    <= uart_hit;
      ld_offset    <= req.addr[1:0];
      ld_size      <= req.size;
      ld_unsigned  <= req.unsigned_ld;
   end

   always_comb begin
      wb.we = we_r;
      wb.rd = rd_r;
      if (!mem_to_reg_r)
         wb.wdata = alu_result_r;
      else if (uart_ld_r)
         wb.wdata = 32'h0000_0000; // uart reads back as zero
      else
         wb.wdata = ld_word;
   end

endmodule

`default_nettype wire

//--- hdl/mem_types_pkg.sv
`default_nettype none

package mem_types_pkg;

   // access size, 3 behaves as word
   typedef enum logic [1:0] {
      size_word = 2'd0,
      size_byte = 2'd1,
      size_half = 2'd2
   } mem_size_e;

   // memory-mapped uart data register
   localparam logic [31:0] uart_addr = 32'h1000_0000;

   // one access from execute
   typedef struct packed {
      logic [31:0] addr;
      mem_size_e   size;
      logic [31:0] wdata;
      logic        store;
      logic        unsigned_ld;
      logic        valid;
   } mem_req_t;

   // ram data word, seen whole or per byte lane
   typedef union packed {
      logic [31:0]     word;
      logic [3:0][7:0] lanes;
   } data_word_u;

endpackage

`default_nettype wire

//--- hdl/pipe_types_pkg.sv
`default_nettype none

package pipe_types_pkg;

   // register writeback fields riding along with the access
   typedef struct packed {
      logic [4:0]  rd;
      logic        reg_we;
      logic        mem_to_reg;
      logic [31:0] alu_result;
   } wb_side_t;

   // result handed to the register file
   typedef struct packed {
      logic [31:0] wdata;
      logic        we;
      logic [4:0]  rd;
   } wb_out_t;

endpackage

`default_nettype wire

//--- hdl/store_align.sv
`timescale 1ns/100ps
`default_nettype none

module store_align (
   input  mem_types_pkg::mem_size_e   size,
   input  wire [1:0]                  offset,
   input  wire [31:0]                 wdata,
   output mem_types_pkg::data_word_u  lane_wdata,
   output logic [3:0]                 lane_be
);

   logic [31:0] masked;
   logic [3:0]  be;

   // trim to access size, lane 0 based
   always_comb begin
      case (size)
         mem_types_pkg::size_byte: begin
            masked = {24'h00_0000, wdata[7:0]};
            be     = 4'b0001;
         end
         mem_types_pkg::size_half: begin
            masked = {16'h0000, wdata[15:0]};
            be     = 4'b0011;
         end
         default: begin
            masked = wdata;
            be     = 4'b1111;
         end
      endcase
   end

   // move up to the addressed lane
   always_comb begin
      lane_wdata.word = masked << {offset, 3'b000};
      lane_be         = be << offset; // upper enables fall off
   end

endmodule

`default_nettype wire
